// ==== bench/trig_tb.sv ====
`timescale 1ns/1ps

module trig_tb;

	logic clock;
	logic reset1;
	logic inhibit;
	logic serial_out;
	trig_pkg::trig_word_t last_word;
	logic heartbeat;

	logic [15:0] lfsr_state;

	// serial line capture and monitor state
	int cap_count;
	trig_pkg::trig_word_t cap_word;
	int exp_index;
	int words_seen;
	int gap;
	logic gap_armed;
	int inhibit_age;
	logic hb_prev;
	int hb_still;
	logic lw_pending;
	trig_pkg::trig_word_t lw_expect;
	int lw_wait;

	trig_top i_dut (
		.clock(clock),
		.reset1(reset1),
		.inhibit(inhibit),
		.serial_out(serial_out),
		.last_word(last_word),
		.heartbeat(heartbeat)
	);

	initial begin
		clock = 1'b0;
		forever begin
			#2 clock = ~clock;
		end
	end

	task automatic stop_with_errors();
		$display("ERRORS FOUND");
		$fatal(1, "simulation stopped at the first error");
	endtask

	task automatic check_failed(input string msg);
		$display("CHECK FAILED at %0t ns: %s", $time, msg);
		stop_with_errors();
	endtask

	task automatic timeout_failed(input string what);
		$display("timed out at %0t ns while waiting for %s", $time, what);
		stop_with_errors();
	endtask

	// x^16 + x^14 + x^13 + x^11 + 1
	function automatic logic [15:0] lfsr_next(input logic [15:0] s);
		logic fb;
		fb = s[15] ^ s[13] ^ s[12] ^ s[10];
		return {s[14:0], fb};
	endfunction

	task automatic random_bits(input int n, output int value);
		value = 0;
		for (int i = 0; i < n; i++) begin
			lfsr_state = lfsr_next(lfsr_state);
			value = (value << 1) | int'(lfsr_state[0]);
		end
	endtask

	// both end bits, plus one walking bit for indices 1 to 6
	function automatic trig_pkg::trig_word_t pattern_rule(input int idx);
		trig_pkg::trig_word_t w;
		w = 8'b1000_0001;
		if (idx >= 1 && idx <= 6) begin
			w = w | (8'b1000_0000 >> idx);
		end
		return w;
	endfunction

	task automatic check_idle_outputs(input string when);
		assert (serial_out === 1'b0 && heartbeat === 1'b0 && last_word === '0)
			else check_failed($sformatf("outputs not zero %s: serial_out=%b heartbeat=%b last_word=%b",
				when, serial_out, heartbeat, last_word));
	endtask

	task automatic wait_words(input int target, input string what);
		int waited;
		int limit;
		waited = 0;
		limit = (target - words_seen + 2) * (trig_pkg::interval_cycles + 16);
		while (words_seen < target) begin
			@(posedge clock);
			waited++;
			if (waited > limit) begin
				timeout_failed(what);
			end
		end
	endtask

	// outputs are sampled on the falling edge, away from the drive edge
	always @(negedge clock) begin : monitor
		logic started;
		if (!reset1) begin
			started = (cap_count == 0) && (serial_out === 1'b1);
			if (started) begin
				cap_word = 8'h01; // msb already seen
				cap_count = 1;
			end else if (cap_count != 0) begin
				cap_word = {cap_word[6:0], serial_out};
				cap_count++;
				if (cap_count == trig_pkg::word_width) begin
					assert (cap_word == pattern_rule(exp_index))
						else check_failed($sformatf("word %0d is %b, expected %b for index %0d",
							words_seen, cap_word, pattern_rule(exp_index), exp_index));
					exp_index = (exp_index + 1) % trig_pkg::pattern_count;
					words_seen++;
					cap_count = 0;
					lw_pending = 1'b1;
					lw_expect = cap_word;
					lw_wait = 0;
				end
			end

			if (lw_pending) begin
				if (last_word == lw_expect) begin
					lw_pending = 1'b0;
				end else begin
					lw_wait++;
					assert (lw_wait <= 3)
						else check_failed($sformatf("last_word %b, expected %b",
							last_word, lw_expect));
				end
			end

			// spacing between word starts while the line is free
			if (started) begin
				gap = 0;
				gap_armed = 1'b1;
			end else if (inhibit) begin
				gap = 0;
			end else begin
				gap++;
			end
			assert (!gap_armed || gap <= trig_pkg::interval_cycles + 16)
				else check_failed($sformatf("no new word for %0d cycles", gap));

			if (heartbeat !== hb_prev) begin
				hb_still = 0;
			end else begin
				hb_still++;
			end
			hb_prev = heartbeat;
			assert (hb_still < 2 * trig_pkg::heartbeat_half)
				else check_failed($sformatf("heartbeat stuck for %0d cycles", hb_still));

			if (inhibit) begin
				inhibit_age++;
			end else begin
				inhibit_age = 0;
			end
		end
	end

	// a frame already running may finish, then the line goes quiet
	quiet_while_inhibited: assert property (@(posedge clock) disable iff (reset1)
		(inhibit_age > 8) |-> (serial_out == 1'b0))
		else check_failed($sformatf("serial_out high %0d cycles into inhibit", inhibit_age));

	initial begin : stimulus
		int hold;
		int on_len;
		int off_len;
		int base;
		reset1 = 1'b1;
		inhibit = 1'b0;
		lfsr_state = 16'd64806;
		cap_count = 0;
		cap_word = '0;
		exp_index = 0;
		words_seen = 0;
		gap = 0;
		gap_armed = 1'b0;
		inhibit_age = 0;
		hb_prev = 1'b0;
		hb_still = 0;
		lw_pending = 1'b0;
		lw_expect = '0;
		lw_wait = 0;

		repeat (2) begin
			@(posedge clock);
			@(negedge clock);
			check_idle_outputs("during reset");
		end
		@(posedge clock);
		reset1 <= 1'b0;
		@(negedge clock);
		check_idle_outputs("at reset release");
		@(posedge clock);
		@(negedge clock);
		check_idle_outputs("on the first cycle after reset");

		wait_words(4, "the first four words");

		// long inhibit, more than three intervals, fills the buffer and stalls
		random_bits(5, hold);
		@(posedge clock);
		inhibit <= 1'b1;
		repeat (3 * trig_pkg::interval_cycles + 16 + hold) @(posedge clock);
		inhibit <= 1'b0;
		base = words_seen;
		wait_words(base + 4, "words held back by inhibit");

		// short random pauses
		repeat (4) begin
			random_bits(4, on_len);
			random_bits(6, off_len);
			@(posedge clock);
			inhibit <= 1'b1;
			repeat (on_len + 1) @(posedge clock);
			inhibit <= 1'b0;
			repeat (off_len + 16) @(posedge clock);
		end

		base = (words_seen + 3 > 14) ? words_seen + 3 : 14;
		wait_words(base, "the closing words");

		$display("NO ERRORS");
		$finish;
	end

endmodule

// ==== files.f ====
rtl/trig_pkg.sv
rtl/trig_sequencer.sv
rtl/pattern_encoder.sv
rtl/word_buffer.sv
rtl/bit_serializer.sv
rtl/status_display.sv
rtl/trig_top.sv
bench/trig_tb.sv

// ==== rtl/bit_serializer.sv ====
`timescale 1ns/1ps

module bit_serializer (
	input logic clock,
	input logic reset1,
	input logic inhibit,
	input logic buf_valid,
	input trig_pkg::trig_word_t buf_word,
	output logic take,
	output logic serial_out,
	output logic load_strobe,
	output trig_pkg::trig_word_t loaded_word
);
	trig_pkg::frame_pos_t frame_pos; // position of the bit now on serial_out
	trig_pkg::trig_word_t shreg;
	logic frame_end;

	assign frame_end = (frame_pos == trig_pkg::frame_pos_t'(trig_pkg::word_width - 1));

	// next frame word is picked on the edge into position 0
	// so inhibit only bites at a frame boundary
	assign take = frame_end && buf_valid && !inhibit;

	always_ff @(posedge clock) begin
		if (reset1) begin
			frame_pos <= '0;
			shreg <= '0;
			serial_out <= 1'b0;
			load_strobe <= 1'b0;
		end else begin
			load_strobe <= take;
			if (frame_end) begin
				frame_pos <= '0;
				if (take) begin
					serial_out <= buf_word[trig_pkg::word_width-1]; // msb first
					shreg <= buf_word << 1;
				end else begin
					serial_out <= 1'b0; // idle frame
					shreg <= '0;
				end
			end else begin
				frame_pos <= frame_pos + 1'b1;
				serial_out <= shreg[trig_pkg::word_width-1];
				shreg <= shreg << 1;
			end
		end
	end

	// copy for the status block, lines up with load_strobe
	always_ff @(posedge clock) begin
		if (take) begin
			loaded_word <= buf_word;
		end
	end

endmodule

// ==== rtl/pattern_encoder.sv ====
`timescale 1ns/1ps

module pattern_encoder (
	input logic clock,
	input logic reset1,
	input logic issue,
	input trig_pkg::pattern_idx_t issue_index,
	output trig_pkg::word_beat_t enc_beat
);
	trig_pkg::trig_word_t word_next;
	trig_pkg::trig_word_t beat_word;
	trig_pkg::pattern_idx_t beat_index;
	logic beat_valid;

	// end bits always set, middle bit walks down from bit 6
	always_comb begin
		word_next = '0;
		word_next[trig_pkg::word_width-1] = 1'b1;
		word_next[0] = 1'b1;
		if (issue_index != '0 &&
			issue_index != trig_pkg::pattern_idx_t'(trig_pkg::pattern_count - 1)) begin
			word_next[trig_pkg::word_width - 1 - int'(issue_index)] = 1'b1;
		end
	end

	always_ff @(posedge clock) begin
		if (reset1) begin
			beat_valid <= 1'b0;
		end else begin
			beat_valid <= issue;
		end
	end

	always_ff @(posedge clock) begin
		if (issue) begin
			beat_index <= issue_index;
			beat_word <= word_next;
		end
	end

	assign enc_beat = '{valid: beat_valid, index: beat_index, word: beat_word};

endmodule

// ==== rtl/status_display.sv ====
`timescale 1ns/1ps

module status_display (
	input logic clock,
	input logic reset1,
	input logic load_strobe,
	input trig_pkg::trig_word_t loaded_word,
	output trig_pkg::trig_word_t last_word,
	output logic heartbeat
);
	logic [trig_pkg::heartbeat_bits-1:0] hb_count;
	logic hb_wrap;

	assign hb_wrap = (hb_count == trig_pkg::heartbeat_bits'(trig_pkg::heartbeat_half - 1));

	// what the board leds would show
	always_ff @(posedge clock) begin
		if (reset1) begin
			last_word <= '0;
		end else if (load_strobe) begin
			last_word <= loaded_word;
		end
	end

	// heartbeat blink, toggles each half-period
	always_ff @(posedge clock) begin
		if (reset1) begin
			hb_count <= '0;
			heartbeat <= 1'b0;
		end else begin
			if (hb_wrap) begin
				hb_count <= '0;
				heartbeat <= !heartbeat;
			end else begin
				hb_count <= hb_count + 1'b1;
			end
		end
	end

endmodule

// ==== rtl/trig_pkg.sv ====
package trig_pkg;

	// word and pattern sizes
	localparam int word_width = 8;
	localparam int pattern_count = 8;

	// clocks between emission attempts, short for simulation
	// must stay at least one serial frame
	localparam int interval_cycles = 64;

	// buffer entries, also the starting credit count
	localparam int credit_depth = 2;

	// heartbeat blink half-period in clocks
	localparam int heartbeat_half = 32;

	// derived counter widths
	localparam int interval_bits = $clog2(interval_cycles);
	localparam int heartbeat_bits = $clog2(heartbeat_half);
	localparam int ptr_bits = (credit_depth > 1) ? $clog2(credit_depth) : 1;

	typedef logic [word_width-1:0] trig_word_t;
	typedef logic [$clog2(pattern_count)-1:0] pattern_idx_t;
	typedef logic [1:0] credit_t; // 0 to credit_depth
	typedef logic [$clog2(word_width)-1:0] frame_pos_t;

	// one encoded trigger word on its way to the buffer
	typedef struct packed {
		logic valid;
		pattern_idx_t index;
		trig_word_t word;
	} word_beat_t;

	typedef enum logic [1:0] {
		seq_wait,  // counting out the interval
		seq_ready, // interval done, issue if a credit is free
		seq_stall  // waiting on a credit from the buffer
	} seq_state_t;

endpackage

// ==== rtl/trig_sequencer.sv ====
`timescale 1ns/1ps

module trig_sequencer (
	input logic clock,
	input logic reset1,
	input logic credit_return,
	output logic issue,
	output trig_pkg::pattern_idx_t issue_index
);
	trig_pkg::seq_state_t state;
	logic [trig_pkg::interval_bits-1:0] interval_count;
	trig_pkg::credit_t credits;
	logic credit_ok;
	logic wrap;

	assign credit_ok = (credits != '0);
	assign wrap = (interval_count == trig_pkg::interval_bits'(trig_pkg::interval_cycles - 1));

	// issue straight out of ready, or first cycle a credit shows up in stall
	assign issue = (state != trig_pkg::seq_wait) && credit_ok;

	always_ff @(posedge clock) begin
		if (reset1) begin
			state <= trig_pkg::seq_wait;
			interval_count <= '0;
		end else begin
			case (state)
				trig_pkg::seq_wait: begin
					if (wrap) begin
						state <= trig_pkg::seq_ready;
						interval_count <= '0; // held at zero until the issue
					end else begin
						interval_count <= interval_count + 1'b1;
					end
				end
				trig_pkg::seq_ready: begin
					if (credit_ok) begin
						state <= trig_pkg::seq_wait;
					end else begin
						state <= trig_pkg::seq_stall;
					end
				end
				trig_pkg::seq_stall: begin
					if (credit_ok) begin
						state <= trig_pkg::seq_wait;
					end
				end
				default: begin
					state <= trig_pkg::seq_wait;
				end
			endcase
		end
	end

	// one credit per buffer entry
	always_ff @(posedge clock) begin
		if (reset1) begin
			credits <= trig_pkg::credit_t'(trig_pkg::credit_depth);
		end else begin
			case ({issue, credit_return})
				2'b10: credits <= credits - 1'b1;
				2'b01: credits <= credits + 1'b1;
				default: credits <= credits; // both or neither
			endcase
		end
	end

	always_ff @(posedge clock) begin
		if (reset1) begin
			issue_index <= '0;
		end else if (issue) begin
			if (issue_index == trig_pkg::pattern_idx_t'(trig_pkg::pattern_count - 1)) begin
				issue_index <= '0;
			end else begin
				issue_index <= issue_index + 1'b1;
			end
		end
	end

endmodule

// ==== rtl/trig_top.sv ====
`timescale 1ns/1ps

module trig_top (
	input logic clock,
	input logic reset1,
	input logic inhibit,
	output logic serial_out,
	output trig_pkg::trig_word_t last_word,
	output logic heartbeat
);
	logic issue;
	trig_pkg::pattern_idx_t issue_index;
	trig_pkg::word_beat_t enc_beat;
	logic buf_valid;
	trig_pkg::trig_word_t buf_word;
	logic take;
	logic credit_return; // buffer back to sequencer
	logic load_strobe;
	trig_pkg::trig_word_t loaded_word;

	trig_sequencer i_sequencer (
		.clock(clock),
		.reset1(reset1),
		.credit_return(credit_return),
		.issue(issue),
		.issue_index(issue_index)
	);

	pattern_encoder i_encoder (
		.clock(clock),
		.reset1(reset1),
		.issue(issue),
		.issue_index(issue_index),
		.enc_beat(enc_beat)
	);

	word_buffer i_buffer (
		.clock(clock),
		.reset1(reset1),
		.enc_beat(enc_beat),
		.take(take),
		.buf_valid(buf_valid),
		.buf_word(buf_word),
		.credit_return(credit_return)
	);

	bit_serializer i_serializer (
		.clock(clock),
		.reset1(reset1),
		.inhibit(inhibit),
		.buf_valid(buf_valid),
		.buf_word(buf_word),
		.take(take),
		.serial_out(serial_out),
		.load_strobe(load_strobe),
		.loaded_word(loaded_word)
	);

	status_display i_status (
		.clock(clock),
		.reset1(reset1),
		.load_strobe(load_strobe),
		.loaded_word(loaded_word),
		.last_word(last_word),
		.heartbeat(heartbeat)
	);

endmodule

// ==== rtl/word_buffer.sv ====
`timescale 1ns/1ps

module word_buffer (
	input logic clock,
	input logic reset1,
	input trig_pkg::word_beat_t enc_beat,
	input logic take,
	output logic buf_valid,
	output trig_pkg::trig_word_t buf_word,
	output logic credit_return
);
	trig_pkg::trig_word_t mem [trig_pkg::credit_depth];
	logic [trig_pkg::ptr_bits-1:0] wr_ptr;
	logic [trig_pkg::ptr_bits-1:0] rd_ptr;
	trig_pkg::credit_t count;
	logic push;
	logic pop;

	// credits upstream keep push from ever landing on a full buffer
	assign push = enc_beat.valid;
	assign pop = take && buf_valid;

	assign buf_valid = (count != '0);
	assign buf_word = mem[rd_ptr];
	assign credit_return = pop; // same cycle as the pop

	always_ff @(posedge clock) begin
		if (push) begin
			mem[wr_ptr] <= enc_beat.word;
		end
	end

	always_ff @(posedge clock) begin
		if (reset1) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
		end else begin
			if (push) begin
				if (wr_ptr == trig_pkg::ptr_bits'(trig_pkg::credit_depth - 1)) begin
					wr_ptr <= '0;
				end else begin
					wr_ptr <= wr_ptr + 1'b1;
				end
			end
			if (pop) begin
				if (rd_ptr == trig_pkg::ptr_bits'(trig_pkg::credit_depth - 1)) begin
					rd_ptr <= '0;
				end else begin
					rd_ptr <= rd_ptr + 1'b1;
				end
			end
			case ({push, pop})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

endmodule

// ==== run.sh ====
#!/usr/bin/env bash
# build and run the trigger transmitter testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing --assert -Wno-fatal \
	--top-module trig_tb -f files.f -o trig_sim \
	&& { ./obj_dir/trig_sim 2>&1 | tee sim.log; } \
	&& test -s sim.log \
	&& ! grep -q "ERRORS FOUND" sim.log \
	&& echo "simulation passed" \
	|| { echo "simulation failed, see sim.log"; exit 1; }
